/* verilog/cache_cfg_pkg.sv */
package cache_cfg_pkg;

    // address space seen by the cache
    localparam int addr_w = 32;

    // line geometry, two 64-bit banks per line
    localparam int line_bytes = 16;
    localparam int offset_w = 4;   // log2 of line_bytes

    // tag width at 128 sets
    // the width follows the set count, so each module works its own width out from sets
    localparam int tag_w = addr_w - offset_w - 7;

    // uncached device region, compared with address bits 31..28
    localparam logic [3:0] mmio_base = 4'ha;

endpackage

/* verilog/mem_bus_pkg.sv */
package mem_bus_pkg;

    // access size as given on req_size
    typedef enum logic [1:0] {
        sz_byte  = 2'd0,
        sz_half  = 2'd1,
        sz_word  = 2'd2,
        sz_dword = 2'd3
    } size_t;

    // one cache line, seen either as banks or as bytes
    typedef union packed {
        logic [1:0][63:0] bank;    // bank[1] holds offsets 8..15
        logic [15:0][7:0] bytes;   // bytes[n] is offset n
    } line_t;

    // controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_refill,
        st_uncached
    } ctrl_state_t;

endpackage

/* verilog/dcache_if.sv */
`timescale 1ns/10ps

// tag/valid/dirty lookup and update between controller and tag array
interface tag_if #(
    parameter int sets = 128,
    parameter int tag_bits = cache_cfg_pkg::tag_w
);
    localparam int idx_w = $clog2(sets);

    logic [idx_w-1:0] index;
    logic [tag_bits-1:0] tag;
    logic fill;          // install tag, valid, dirty from mark_dirty
    logic clean;         // victim written back
    logic mark_dirty;
    logic way;

    logic hit;
    logic hit_way;
    logic victim_way;
    logic victim_dirty;
    logic [tag_bits-1:0] victim_tag;

    modport ctrl (
        output index, tag, fill, clean, mark_dirty, way,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport array (
        input  index, tag, fill, clean, mark_dirty, way,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );
endinterface

// line data path between controller, store merge and data array
interface line_if #(
    parameter int sets = 128
);
    localparam int idx_w = $clog2(sets);

    logic [idx_w-1:0] index;
    logic read_en;
    logic write_way;
    logic write_en;
    mem_bus_pkg::line_t wline;
    logic [cache_cfg_pkg::line_bytes-1:0] byte_en;
    mem_bus_pkg::line_t rline0;
    mem_bus_pkg::line_t rline1;

    modport ctrl (
        output index, read_en, write_way, write_en,
        input  wline, byte_en, rline0, rline1
    );

    modport merge (output wline, byte_en);

    modport array (
        input  index, read_en, write_way, write_en, wline, byte_en,
        output rline0, rline1
    );
endinterface

/* verilog/dcache_tag_array.sv */
`timescale 1ns/10ps

module dcache_tag_array #(
    parameter int sets = 128
) (
    input logic clk,
    input logic rst,
    tag_if.array tif
);
    localparam int idx_w = $clog2(sets);
    localparam int tw = cache_cfg_pkg::addr_w - cache_cfg_pkg::offset_w - idx_w;

    logic [tw-1:0] tags [2][sets];
    logic [1:0][sets-1:0] valid;
    logic [1:0][sets-1:0] dirty;
    logic rr;              // round-robin pick when both ways look alike
    logic [1:0] match;
    logic victim;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = valid[w][tif.index] && (tags[w][tif.index] == tif.tag);
        end
    end

    assign tif.hit = |match;
    assign tif.hit_way = match[1];

    // invalid way first, then the clean one, then round robin
    always_comb begin
        if (!valid[0][tif.index]) begin
            victim = 1'b0;
        end else if (!valid[1][tif.index]) begin
            victim = 1'b1;
        end else if (dirty[0][tif.index] != dirty[1][tif.index]) begin
            victim = dirty[0][tif.index];   // way 0 dirty means way 1 is clean
        end else begin
            victim = rr;
        end
    end

    assign tif.victim_way = victim;
    assign tif.victim_dirty = valid[victim][tif.index] && dirty[victim][tif.index];
    assign tif.victim_tag = tags[victim][tif.index];

    always_ff @(posedge clk) begin
        if (tif.fill) begin
            tags[tif.way][tif.index] <= tif.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
            rr <= 1'b0;
        end else if (tif.fill) begin
            valid[tif.way][tif.index] <= 1'b1;
            dirty[tif.way][tif.index] <= tif.mark_dirty;   // dirty on write allocate
            rr <= ~rr;
        end else if (tif.clean) begin
            dirty[tif.way][tif.index] <= 1'b0;
        end else if (tif.mark_dirty) begin
            dirty[tif.way][tif.index] <= 1'b1;
        end
    end

endmodule

/* verilog/dcache_data_array.sv */
`timescale 1ns/10ps

module dcache_data_array #(
    parameter int sets = 128
) (
    input logic clk,
    line_if.array lif
);
    mem_bus_pkg::line_t ways [2][sets];

    // read data held until the next read_en
    always_ff @(posedge clk) begin
        if (lif.read_en) begin
            lif.rline0 <= ways[0][lif.index];
            lif.rline1 <= ways[1][lif.index];
        end
    end

    always_ff @(posedge clk) begin
        if (lif.write_en) begin
            for (int b = 0; b < cache_cfg_pkg::line_bytes; b++) begin
                if (lif.byte_en[b]) begin
                    ways[lif.write_way][lif.index].bytes[b] <= lif.wline.bytes[b];
                end
            end
        end
    end

endmodule

/* verilog/dcache_store_merge.sv */
`timescale 1ns/10ps

module dcache_store_merge (
    input mem_bus_pkg::line_t base_line,
    input logic [cache_cfg_pkg::offset_w-1:0] offset,
    input mem_bus_pkg::size_t req_size,
    input logic [63:0] req_wdata,
    input logic store_en,
    line_if.merge lif
);
    logic [cache_cfg_pkg::line_bytes-1:0] size_mask;
    logic [cache_cfg_pkg::line_bytes-1:0] mask;
    mem_bus_pkg::line_t shifted;
    mem_bus_pkg::line_t merged;

    always_comb begin
        case (req_size)
            mem_bus_pkg::sz_byte: size_mask = 16'h0001;
            mem_bus_pkg::sz_half: size_mask = 16'h0003;
            mem_bus_pkg::sz_word: size_mask = 16'h000f;
            default:              size_mask = 16'h00ff;
        endcase
    end

    assign mask = size_mask << offset;   // accesses are aligned, nothing falls off
    assign shifted = {64'b0, req_wdata} << {offset, 3'b000};

    always_comb begin
        for (int b = 0; b < cache_cfg_pkg::line_bytes; b++) begin
            if (store_en && mask[b]) begin
                merged.bytes[b] = shifted.bytes[b];
            end else begin
                merged.bytes[b] = base_line.bytes[b];
            end
        end
    end

    assign lif.wline = merged;
    assign lif.byte_en = store_en ? mask : '1;   // whole line when just passing base through

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int sets = 128
) (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic req_write,
    input  logic [cache_cfg_pkg::addr_w-1:0] req_addr,
    output logic resp_done,
    output logic [63:0] resp_rdata,
    output logic mem_req_valid,
    output logic mem_req_wen,
    output logic [cache_cfg_pkg::addr_w-1:0] mem_req_addr,
    output mem_bus_pkg::line_t mem_req_data,
    output logic [7:0] mem_req_strb,
    input  logic mem_res_valid,
    input  mem_bus_pkg::line_t mem_res_data,
    tag_if.ctrl tif,
    line_if.ctrl lif,
    output mem_bus_pkg::line_t base_line,
    output logic store_en,
    output logic [cache_cfg_pkg::offset_w-1:0] offset
);
    localparam int aw = cache_cfg_pkg::addr_w;
    localparam int ow = cache_cfg_pkg::offset_w;
    localparam int idx_w = $clog2(sets);

    mem_bus_pkg::ctrl_state_t state;
    logic way_q;            // hit way or chosen victim
    logic start;
    logic region;
    logic issue;
    logic lookup_store;
    logic [7:0] strb_lane;
    logic [aw-1:0] victim_addr;
    mem_bus_pkg::line_t rsel;

    assign start = req_valid && !resp_done;   // request still held in the done cycle
    assign region = req_addr[aw-1 -: 4] == cache_cfg_pkg::mmio_base;
    assign offset = req_addr[ow-1:0];
    assign rsel = way_q ? lif.rline1 : lif.rline0;
    assign lookup_store = (state == mem_bus_pkg::st_lookup) && req_write;

    assign tif.index = req_addr[ow +: idx_w];
    assign tif.tag = req_addr[aw-1:ow+idx_w];
    assign tif.way = way_q;
    assign tif.fill = (state == mem_bus_pkg::st_refill) && mem_res_valid;
    assign tif.clean = (state == mem_bus_pkg::st_writeback) && mem_res_valid;
    assign tif.mark_dirty = req_write && (tif.fill || state == mem_bus_pkg::st_lookup);

    assign lif.index = req_addr[ow +: idx_w];
    assign lif.read_en = (state == mem_bus_pkg::st_idle) && start;
    assign lif.write_way = way_q;
    assign lif.write_en = lookup_store || tif.fill;   // hit store or line refill

    // refill writes the memory line as is, a missed store lands on the replayed hit
    assign store_en = lookup_store || state == mem_bus_pkg::st_uncached;

    always_comb begin
        case (state)
            mem_bus_pkg::st_refill:   base_line = mem_res_data;
            mem_bus_pkg::st_uncached: base_line = '0;
            default:                  base_line = rsel;
        endcase
    end

    always_comb begin
        mem_req_data = '0;
        if (state == mem_bus_pkg::st_writeback) begin
            mem_req_data = rsel;
        end else if (state == mem_bus_pkg::st_uncached) begin
            mem_req_data.bank[0] = lif.wline.bank[offset[3]];   // store bytes in their lane
        end
    end

    assign strb_lane = offset[3] ? lif.byte_en[15:8] : lif.byte_en[7:0];
    assign victim_addr = {tif.victim_tag, tif.index, {ow{1'b0}}};
    assign issue = !mem_req_valid && (state == mem_bus_pkg::st_writeback ||
                                      state == mem_bus_pkg::st_refill ||
                                      state == mem_bus_pkg::st_uncached);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mem_bus_pkg::st_idle;
            way_q <= 1'b0;
            resp_done <= 1'b0;
            mem_req_valid <= 1'b0;
            mem_req_wen <= 1'b0;
        end else begin
            resp_done <= 1'b0;
            case (state)
                mem_bus_pkg::st_idle: begin
                    if (start) begin
                        if (region) begin
                            state <= mem_bus_pkg::st_uncached;
                        end else if (tif.hit) begin
                            state <= mem_bus_pkg::st_lookup;
                            way_q <= tif.hit_way;
                        end else begin
                            way_q <= tif.victim_way;
                            state <= tif.victim_dirty ? mem_bus_pkg::st_writeback
                                                      : mem_bus_pkg::st_refill;
                        end
                    end
                end
                mem_bus_pkg::st_lookup: begin
                    resp_done <= 1'b1;
                    state <= mem_bus_pkg::st_idle;
                end
                mem_bus_pkg::st_writeback: begin
                    if (mem_res_valid) state <= mem_bus_pkg::st_refill;
                end
                mem_bus_pkg::st_refill: begin
                    if (mem_res_valid) state <= mem_bus_pkg::st_idle;   // replay as a hit
                end
                mem_bus_pkg::st_uncached: begin
                    if (mem_res_valid) begin
                        resp_done <= 1'b1;
                        state <= mem_bus_pkg::st_idle;
                    end
                end
                default: state <= mem_bus_pkg::st_idle;
            endcase

            // request drops on the response edge, next one starts a cycle later
            if (mem_res_valid) begin
                mem_req_valid <= 1'b0;
                mem_req_wen <= 1'b0;
            end else if (issue) begin
                mem_req_valid <= 1'b1;
                mem_req_wen <= (state == mem_bus_pkg::st_writeback) ||
                               (state == mem_bus_pkg::st_uncached && req_write);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            case (state)
                mem_bus_pkg::st_writeback: begin
                    mem_req_addr <= victim_addr;
                    mem_req_strb <= 8'hff;
                end
                mem_bus_pkg::st_uncached: begin
                    mem_req_addr <= {req_addr[aw-1:3], 3'b000};
                    mem_req_strb <= strb_lane;
                end
                default: begin
                    mem_req_addr <= {req_addr[aw-1:ow], {ow{1'b0}}};
                    mem_req_strb <= 8'hff;
                end
            endcase
        end
        if (state == mem_bus_pkg::st_lookup) begin
            resp_rdata <= rsel.bank[offset[3]];
        end else if (state == mem_bus_pkg::st_uncached && mem_res_valid) begin
            resp_rdata <= mem_res_data.bank[0];   // device data in the low bank
        end
    end

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top #(
    parameter int sets = 128
) (
    input  logic clk,
    input  logic rst,
    input  logic req_valid,
    input  logic req_write,
    input  logic [cache_cfg_pkg::addr_w-1:0] req_addr,
    input  logic [63:0] req_wdata,
    input  mem_bus_pkg::size_t req_size,
    output logic resp_done,
    output logic [63:0] resp_rdata,
    output logic mem_req_valid,
    output logic mem_req_wen,
    output logic [cache_cfg_pkg::addr_w-1:0] mem_req_addr,
    output mem_bus_pkg::line_t mem_req_data,
    output logic [7:0] mem_req_strb,
    input  logic mem_res_valid,
    input  mem_bus_pkg::line_t mem_res_data
);
    localparam int idx_w = $clog2(sets);
    localparam int tag_bits = cache_cfg_pkg::addr_w - cache_cfg_pkg::offset_w - idx_w;

    tag_if #(.sets(sets), .tag_bits(tag_bits)) tif ();
    line_if #(.sets(sets)) lif ();

    mem_bus_pkg::line_t base_line;
    logic store_en;
    logic [cache_cfg_pkg::offset_w-1:0] offset;

    dcache_ctrl #(.sets(sets)) i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .resp_done     (resp_done),
        .resp_rdata    (resp_rdata),
        .mem_req_valid (mem_req_valid),
        .mem_req_wen   (mem_req_wen),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_strb  (mem_req_strb),
        .mem_res_valid (mem_res_valid),
        .mem_res_data  (mem_res_data),
        .tif           (tif),
        .lif           (lif),
        .base_line     (base_line),
        .store_en      (store_en),
        .offset        (offset)
    );

    dcache_tag_array #(.sets(sets)) i_tag_array (
        .clk (clk),
        .rst (rst),
        .tif (tif)
    );

    dcache_data_array #(.sets(sets)) i_data_array (
        .clk (clk),
        .lif (lif)
    );

    dcache_store_merge i_store_merge (
        .base_line (base_line),
        .offset    (offset),
        .req_size  (req_size),
        .req_wdata (req_wdata),
        .store_en  (store_en),
        .lif       (lif)
    );

endmodule

/* verification/dcache_checker.sv */
`timescale 1ns/10ps

module dcache_checker (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_write,
    input logic [31:0] req_addr,
    input logic [63:0] req_wdata,
    input mem_bus_pkg::size_t req_size,
    input logic resp_done,
    input logic [63:0] resp_rdata,
    input logic mem_req_valid,
    input logic mem_req_wen,
    input logic [31:0] mem_req_addr,
    input mem_bus_pkg::line_t mem_req_data,
    input logic [7:0] mem_req_strb,
    input logic [63:0] exp_rdata,
    input logic exp_hit,
    input logic run_over,
    input int timeouts,
    output int error_count
);
    int errors = 0;
    int responses = 0;
    int mem_checks = 0;
    int cycles = 0;
    logic pending = 1'b0;
    logic mem_valid_prev = 1'b0;
    logic rst_seen = 1'b0;

    assign error_count = errors;

    // bytes covered by an access of 2**size bytes
    function automatic logic [7:0] byte_mask(input mem_bus_pkg::size_t size);
        int nbytes;
        nbytes = 1 << size;
        return 8'((16'h1 << nbytes) - 16'h1);
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("error at %0t: %s", $time, what);
        errors++;
    endtask

    // device region goes out as one aligned doubleword and lines go out whole
    task automatic verify_mem_request;
        logic [7:0] strb_exp;
        mem_checks++;
        if (req_addr[31:28] == cache_cfg_pkg::mmio_base) begin
            strb_exp = byte_mask(req_size) << req_addr[2:0];
            check_value("mem_req_addr", 64'(mem_req_addr), 64'({req_addr[31:3], 3'b000}));
            check_value("mem_req_wen", 64'(mem_req_wen), 64'(req_write));
            check_value("mem_req_strb", 64'(mem_req_strb), 64'(strb_exp));
            if (req_write) begin
                check_value("mem_req_data", mem_req_data.bank[0],
                            req_wdata << {req_addr[2:0], 3'b000});
            end
        end else if (!mem_req_wen) begin
            check_value("mem_req_addr", 64'(mem_req_addr), 64'({req_addr[31:4], 4'h0}));
        end else begin
            check_value("mem_req_addr[3:0]", 64'(mem_req_addr[3:0]), 64'h0);
        end
    endtask

    always @(posedge clk) begin
        if (rst) rst_seen <= 1'b1;
    end

    always @(negedge clk) begin
        if (rst) begin
            if (rst_seen) begin   // outputs must be idle once reset has been clocked
                check_value("resp_done", 64'(resp_done), 64'h0);
                check_value("mem_req_valid", 64'(mem_req_valid), 64'h0);
                check_value("mem_req_wen", 64'(mem_req_wen), 64'h0);
            end
            pending = 1'b0;
        end else begin
            if (!pending && req_valid && !resp_done) begin
                pending = 1'b1;
                cycles = 0;
            end else if (pending) begin
                cycles++;
            end
            if (pending && mem_req_valid && !mem_valid_prev) verify_mem_request();
            if (resp_done) begin
                if (!pending) begin
                    report_failure("resp_done without an outstanding request");
                end else begin
                    responses++;
                    if (!req_write) check_value("resp_rdata", resp_rdata, exp_rdata);
                    if (exp_hit && cycles != 2) begin
                        report_failure($sformatf("hit on %h took %0d cycles instead of 2",
                                                 req_addr, cycles));
                    end
                end
                pending = 1'b0;
            end
        end
        mem_valid_prev = mem_req_valid;
    end

    always @(posedge run_over) begin
        $display("checker: %0d responses, %0d memory requests, %0d errors, %0d timeouts",
                 responses, mem_checks, errors, timeouts);
    end

endmodule

/* verification/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;
    localparam int max_words = 320;   // five words per access
    localparam int done_limit = 200;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_write;
    logic [31:0] req_addr;
    logic [63:0] req_wdata;
    mem_bus_pkg::size_t req_size;
    logic resp_done;
    logic [63:0] resp_rdata;
    logic mem_req_valid;
    logic mem_req_wen;
    logic [31:0] mem_req_addr;
    mem_bus_pkg::line_t mem_req_data;
    logic [7:0] mem_req_strb;
    logic mem_res_valid;
    mem_bus_pkg::line_t mem_res_data;

    logic [63:0] exp_rdata;
    logic exp_hit;
    logic run_over;
    int timeouts;
    int error_count;
    int seed = 32'h65bf82ca;
    int uncached_reads = 0;
    logic [63:0] golden [max_words];
    logic [63:0] mem_words [logic [28:0]];   // only doublewords written so far

    dcache_top #(.sets(128)) i_dcache_top (.*);

    dcache_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // untouched memory holds {a, ~a} for the doubleword at a
    function automatic logic [63:0] read_dword(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:3], 3'b000};
        if (mem_words.exists(a[31:3])) return mem_words[a[31:3]];
        return {a, ~a};
    endfunction

    task automatic serve_request;
        logic [63:0] word;
        logic [31:0] a;
        mem_res_data = '0;
        if (mem_req_addr[31:28] == cache_cfg_pkg::mmio_base) begin
            if (mem_req_wen) begin
                $display("uncached write addr %h strb %h data %h",
                         mem_req_addr, mem_req_strb, mem_req_data.bank[0]);
            end else begin
                uncached_reads++;
                mem_res_data.bank[0] = 64'(uncached_reads);
            end
        end else begin
            for (int b = 0; b < 2; b++) begin
                a = mem_req_addr + 32'(8 * b);
                word = read_dword(a);
                if (mem_req_wen) begin
                    for (int i = 0; i < 8; i++) begin
                        if (mem_req_strb[i]) word[8*i +: 8] = mem_req_data.bank[b][8*i +: 8];
                    end
                    mem_words[a[31:3]] = word;
                end else begin
                    mem_res_data.bank[b] = word;
                end
            end
        end
    endtask

    initial begin : memory_model
        int delay;
        mem_res_valid = 1'b0;
        mem_res_data = '0;
        forever begin
            @(negedge clk);
            if (mem_req_valid && !rst) begin
                delay = 1 + int'($unsigned($random(seed)) % 6);
                repeat (delay) @(posedge clk);
                #1;
                serve_request();
                mem_res_valid = 1'b1;   // one-cycle strobe
                @(posedge clk);
                #1;
                mem_res_valid = 1'b0;
            end
        end
    end

    task automatic wait_done(input int access);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!resp_done && cycles < done_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!resp_done) begin
            $display("timeout: access %0d got no resp_done within %0d cycles", access, done_limit);
            timeouts++;
        end
    endtask

    initial begin : driver
        int n;
        int rec;
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_size = mem_bus_pkg::sz_byte;
        exp_rdata = '0;
        exp_hit = 1'b0;
        run_over = 1'b0;
        timeouts = 0;
        $readmemh("verification/dcache_golden.txt", golden);
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        n = 0;
        rec = 0;
        while (n + 4 < max_words && golden[n] != 64'hf && timeouts == 0) begin
            @(posedge clk);
            #1;
            req_valid = 1'b1;
            req_write = golden[n] == 64'h1;
            exp_hit = golden[n] == 64'h2;
            req_addr = golden[n+1][31:0];
            req_size = mem_bus_pkg::size_t'(golden[n+2][1:0]);
            req_wdata = golden[n+3];
            exp_rdata = golden[n+4];
            wait_done(rec);
            n += 5;
            rec++;
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        repeat (4) @(posedge clk);
        run_over = 1'b1;
        #1;
        if (error_count == 0 && timeouts == 0 && rec > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* all.f */
verilog/cache_cfg_pkg.sv
verilog/mem_bus_pkg.sv
verilog/dcache_if.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_store_merge.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_checker.sv
verification/tb_dcache.sv

/* run.sh */
#!/bin/sh
# compile and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/10ps -f all.f --top-module tb_dcache \
        -Mdir obj_dir -o sim_dcache; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_dcache > sim.log 2>&1; then
    cat sim.log
    echo "simulation did not exit cleanly"
    exit 1
fi
cat sim.log

if grep -q "^All checks passed$" sim.log; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

/* verification/dcache_golden.txt */
// op (0 read, 1 write, 2 read that must hit in 2 cycles), address, size (0 byte .. 3 dword),
// write data in the low end, expected read data; op f ends the list
0 00001008 3 0000000000000000 00001008ffffeff7
2 00001008 3 0000000000000000 00001008ffffeff7
// stores on a hit
1 00001001 0 00000000000000aa 0000000000000000
1 00001006 1 0000000000001234 0000000000000000
2 00001000 3 0000000000000000 12341000ffffaaff
// stores that write-allocate
1 00003014 2 00000000deadbeef 0000000000000000
2 00003010 3 0000000000000000 deadbeefffffcfef
1 00003027 0 0000000000000077 0000000000000000
2 00003020 3 0000000000000000 77003020ffffcfdf
1 0000304a 1 000000000000beef 0000000000000000
2 00003048 3 0000000000000000 00003048beefcfb7
// set 0 thrash, dirty lines go back to memory
0 00001800 3 0000000000000000 00001800ffffe7ff
1 00001808 3 5555666677778888 0000000000000000
1 00002000 3 0123456789abcdef 0000000000000000
0 00002800 3 0000000000000000 00002800ffffd7ff
0 00001000 3 0000000000000000 12341000ffffaaff
2 00001008 3 0000000000000000 00001008ffffeff7
0 00001808 3 0000000000000000 5555666677778888
2 00002000 3 0000000000000000 0123456789abcdef
// device region, reads count up
0 a0000010 3 0000000000000000 0000000000000001
0 a0000010 3 0000000000000000 0000000000000002
1 a0000106 1 000000000000cafe 0000000000000000
1 a0000023 0 000000000000005a 0000000000000000
0 a0000010 3 0000000000000000 0000000000000003
f 00000000 0 0000000000000000 0000000000000000
